// File: logic/adam_settings.svh
`ifndef ADAM_SETTINGS_SVH
`define ADAM_SETTINGS_SVH

// bus widths
`define ADAM_ADDR_WIDTH 32
`define ADAM_DATA_WIDTH 32
`define ADAM_STRB_WIDTH (`ADAM_DATA_WIDTH/8)

// lpmem sits at address 0, one word per entry
`define ADAM_LPMEM_WORDS 256

// syscfg window
`define ADAM_SYSCFG_BASE 32'h0001_0000
`define ADAM_SYSCFG_SIZE 256

// controlled units and their boot vector after reset
`define ADAM_NO_UNITS 4
`define ADAM_BOOT_ADDR_RST 32'h0000_0080

`endif

// File: logic/adam_pkg.sv
`include "adam_settings.svh"

package adam_pkg;

    // one request address, read either as an lpmem word index
    // or as a syscfg unit/register selector
    typedef union packed {
        struct packed {
            logic [`ADAM_ADDR_WIDTH-$clog2(`ADAM_LPMEM_WORDS)
                   -$clog2(`ADAM_STRB_WIDTH)-1:0] upper;
            logic [$clog2(`ADAM_LPMEM_WORDS)-1:0] word;
            logic [$clog2(`ADAM_STRB_WIDTH)-1:0]  byte_off;
        } mem;
        struct packed {
            logic [`ADAM_ADDR_WIDTH-$clog2(`ADAM_SYSCFG_SIZE)-1:0] upper;
            // 0x10 bytes per unit
            logic [3:0] unit;
            // 0 = ctrl, 1 = boot
            logic [1:0] reg_sel;
            logic [$clog2(`ADAM_STRB_WIDTH)-1:0] byte_off;
        } cfg;
    } bus_addr_u;

endpackage

// File: logic/adam_req_if.sv
`timescale 1ns/1ps

`include "adam_settings.svh"

interface adam_req_if;

    // request side, from decode
    logic fire;
    logic sel_mem;
    logic sel_cfg;
    logic err;
    adam_pkg::bus_addr_u addr;
    logic we;
    logic [`ADAM_STRB_WIDTH-1:0] be;
    logic [`ADAM_DATA_WIDTH-1:0] wdata;

    // read data from the targets
    logic [`ADAM_DATA_WIDTH-1:0] mem_rdata;
    logic [`ADAM_DATA_WIDTH-1:0] cfg_rdata;

    // from the response stage
    logic ready;

    modport decode (
        output fire, sel_mem, sel_cfg, err, addr, we, be, wdata,
        input  ready
    );

    modport target (
        input  fire, sel_mem, sel_cfg, err, addr, we, be, wdata,
        output mem_rdata, cfg_rdata
    );

    modport result (
        input  fire, sel_mem, sel_cfg, err, we, mem_rdata, cfg_rdata,
        output ready
    );

endinterface

// File: logic/adam_req_decode.sv
`timescale 1ns/1ps

`include "adam_settings.svh"

module adam_req_decode (
    input  logic clk,
    input  logic rst_i,

    input  logic                        req_valid_i,
    input  logic [`ADAM_ADDR_WIDTH-1:0] req_addr_i,
    input  logic                        req_we_i,
    input  logic [`ADAM_STRB_WIDTH-1:0] req_be_i,
    input  logic [`ADAM_DATA_WIDTH-1:0] req_wdata_i,

    adam_req_if.decode bus
);

    localparam logic [`ADAM_ADDR_WIDTH-1:0] CFG_BASE = `ADAM_SYSCFG_BASE;
    localparam int CFG_LSB = $clog2(`ADAM_SYSCFG_SIZE);

    adam_pkg::bus_addr_u addr;
    logic in_mem;
    logic in_cfg;
    logic misaligned;
    logic bad_cfg;

    assign addr = req_addr_i;

    // window match on the upper bits only
    assign in_mem = (addr.mem.upper == '0);
    assign in_cfg = (addr.cfg.upper == CFG_BASE[`ADAM_ADDR_WIDTH-1:CFG_LSB]);

    assign misaligned = (addr.mem.byte_off != '0);

    // reg selects 2 and 3 are holes, as are units past the last one
    assign bad_cfg = addr.cfg.reg_sel[1] || (int'(addr.cfg.unit) >= `ADAM_NO_UNITS);

    assign bus.sel_mem = in_mem && !misaligned;
    assign bus.sel_cfg = in_cfg && !misaligned && !bad_cfg;
    assign bus.err     = !(in_mem || in_cfg) || misaligned || (in_cfg && bad_cfg);

    // single accept strobe for all targets and the response stage
    assign bus.fire = req_valid_i && bus.ready;

    assign bus.addr  = addr;
    assign bus.we    = req_we_i;
    assign bus.be    = req_be_i;
    assign bus.wdata = req_wdata_i;

    a_one_target : assert property (
        @(posedge clk) disable iff (rst_i)
        req_valid_i |-> !(bus.sel_mem && bus.sel_cfg)
    );

    a_err_no_sel : assert property (
        @(posedge clk) disable iff (rst_i)
        bus.fire && bus.err |-> !bus.sel_mem && !bus.sel_cfg
    );

endmodule

// File: logic/adam_lpmem.sv
`timescale 1ns/1ps

`include "adam_settings.svh"

module adam_lpmem (
    input logic clk,

    adam_req_if.target bus
);

    logic [`ADAM_DATA_WIDTH-1:0] mem [`ADAM_LPMEM_WORDS];
    logic wr_en;

    assign wr_en = bus.fire && bus.sel_mem && bus.we;

    // byte lanes written independently
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < `ADAM_STRB_WIDTH; i++) begin
                if (bus.be[i]) begin
                    mem[bus.addr.mem.word][i*8 +: 8] <= bus.wdata[i*8 +: 8];
                end
            end
        end
    end

    // read is asynchronous, the response stage registers it
    assign bus.mem_rdata = mem[bus.addr.mem.word];

endmodule

// File: logic/adam_syscfg.sv
`timescale 1ns/1ps

`include "adam_settings.svh"

module adam_syscfg (
    input  logic clk,
    input  logic rst_i,

    adam_req_if.target bus,

    output logic [`ADAM_NO_UNITS-1:0]                       unit_rst_o,
    output logic [`ADAM_NO_UNITS-1:0]                       unit_pause_o,
    output logic [`ADAM_NO_UNITS-1:0][`ADAM_ADDR_WIDTH-1:0] unit_boot_addr_o
);

    logic [$clog2(`ADAM_NO_UNITS)-1:0] unit;
    logic wr_en;
    logic [`ADAM_DATA_WIDTH-1:0] rdata;

    // decode has already rejected out of range units
    assign unit  = bus.addr.cfg.unit[$clog2(`ADAM_NO_UNITS)-1:0];
    assign wr_en = bus.fire && bus.sel_cfg && bus.we;

    // units come out of reset held in reset, running, at the default vector
    always_ff @(posedge clk) begin
        if (rst_i) begin
            unit_rst_o       <= '1;
            unit_pause_o     <= '0;
            unit_boot_addr_o <= {`ADAM_NO_UNITS{`ADAM_BOOT_ADDR_RST}};
        end
        else if (wr_en) begin
            // full word write, strobe not used here
            case (bus.addr.cfg.reg_sel)
                2'd0: begin
                    unit_rst_o[unit]   <= bus.wdata[0];
                    unit_pause_o[unit] <= bus.wdata[1];
                end
                2'd1: begin
                    unit_boot_addr_o[unit] <= bus.wdata;
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        rdata = '0;
        case (bus.addr.cfg.reg_sel)
            // ctrl, upper bits read as zero
            2'd0: rdata[1:0] = {unit_pause_o[unit], unit_rst_o[unit]};
            2'd1: rdata = unit_boot_addr_o[unit];
            default: rdata = '0;
        endcase
    end

    assign bus.cfg_rdata = rdata;

    a_err_no_write : assert property (
        @(posedge clk) disable iff (rst_i)
        bus.err |=> $stable(unit_rst_o) && $stable(unit_pause_o)
                    && $stable(unit_boot_addr_o)
    );

endmodule

// File: logic/adam_rsp_reg.sv
`timescale 1ns/1ps

`include "adam_settings.svh"

module adam_rsp_reg (
    input  logic clk,
    input  logic rst_i,

    adam_req_if.result bus,

    input  logic                        rsp_ready_i,
    output logic                        rsp_valid_o,
    output logic [`ADAM_DATA_WIDTH-1:0] rsp_rdata_o,
    output logic                        rsp_err_o
);

    logic [`ADAM_DATA_WIDTH-1:0] rdata_d;

    // room for a new request once the held response is empty or leaving
    assign bus.ready = !rsp_valid_o || rsp_ready_i;

    // writes and errors answer with zero
    always_comb begin
        rdata_d = '0;
        if (!bus.we && !bus.err) begin
            if (bus.sel_mem) begin
                rdata_d = bus.mem_rdata;
            end
            else if (bus.sel_cfg) begin
                rdata_d = bus.cfg_rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rsp_valid_o <= 1'b0;
        end
        else if (bus.fire) begin
            rsp_valid_o <= 1'b1;
        end
        else if (rsp_ready_i) begin
            rsp_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.fire) begin
            rsp_rdata_o <= rdata_d;
            rsp_err_o   <= bus.err;
        end
    end

    a_rsp_hold : assert property (
        @(posedge clk) disable iff (rst_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_rdata_o)
                                        && $stable(rsp_err_o)
    );

endmodule

// File: logic/adam_lsdom.sv
`timescale 1ns/1ps

`include "adam_settings.svh"

module adam_lsdom (
    input  logic clk,
    input  logic rst_i,

    // request channel
    input  logic                        req_valid_i,
    output logic                        req_ready_o,
    input  logic [`ADAM_ADDR_WIDTH-1:0] req_addr_i,
    input  logic                        req_we_i,
    input  logic [`ADAM_STRB_WIDTH-1:0] req_be_i,
    input  logic [`ADAM_DATA_WIDTH-1:0] req_wdata_i,

    // response channel
    output logic                        rsp_valid_o,
    input  logic                        rsp_ready_i,
    output logic [`ADAM_DATA_WIDTH-1:0] rsp_rdata_o,
    output logic                        rsp_err_o,

    // unit control levels
    output logic [`ADAM_NO_UNITS-1:0]                       unit_rst_o,
    output logic [`ADAM_NO_UNITS-1:0]                       unit_pause_o,
    output logic [`ADAM_NO_UNITS-1:0][`ADAM_ADDR_WIDTH-1:0] unit_boot_addr_o
);

    adam_req_if req_bus ();

    assign req_ready_o = req_bus.ready;

    adam_req_decode i_adam_req_decode (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_addr_i  (req_addr_i),
        .req_we_i    (req_we_i),
        .req_be_i    (req_be_i),
        .req_wdata_i (req_wdata_i),
        .bus         (req_bus.decode)
    );

    adam_lpmem i_adam_lpmem (
        .clk (clk),
        .bus (req_bus.target)
    );

    adam_syscfg i_adam_syscfg (
        .clk              (clk),
        .rst_i            (rst_i),
        .bus              (req_bus.target),
        .unit_rst_o       (unit_rst_o),
        .unit_pause_o     (unit_pause_o),
        .unit_boot_addr_o (unit_boot_addr_o)
    );

    adam_rsp_reg i_adam_rsp_reg (
        .clk         (clk),
        .rst_i       (rst_i),
        .bus         (req_bus.result),
        .rsp_ready_i (rsp_ready_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_rdata_o (rsp_rdata_o),
        .rsp_err_o   (rsp_err_o)
    );

endmodule

// File: test/adam_lsdom_tb.sv
`timescale 1ns/1ps

`include "adam_settings.svh"

module adam_lsdom_tb;

    // roughly ten times what the directed tests need
    localparam int MAX_CYCLES = 20000;
    localparam int MEM_WORDS  = `ADAM_LPMEM_WORDS;

    logic clk = 1'b0;
    logic rst_i = 1'b1;
    logic req_valid_i = 1'b0;
    logic req_we_i = 1'b0;
    logic rsp_ready_i = 1'b1;
    logic [`ADAM_STRB_WIDTH-1:0] req_be_i = '0;
    logic [`ADAM_ADDR_WIDTH-1:0] req_addr_i = '0;
    logic [`ADAM_DATA_WIDTH-1:0] req_wdata_i = '0;
    logic req_ready_o, rsp_valid_o, rsp_err_o;
    logic [`ADAM_DATA_WIDTH-1:0] rsp_rdata_o;
    logic [`ADAM_NO_UNITS-1:0] unit_rst_o, unit_pause_o;
    logic [`ADAM_NO_UNITS-1:0][`ADAM_ADDR_WIDTH-1:0] unit_boot_addr_o;

    // reference models of lpmem and syscfg
    logic [31:0] mem_model [MEM_WORDS];
    logic [1:0]  ctrl_model [`ADAM_NO_UNITS];
    logic [31:0] boot_model [`ADAM_NO_UNITS];
    int value_errors = 0;
    int other_errors = 0;
    int cycles = 0;

    adam_lsdom i_dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] cfg_addr(input int unit, input int sel);
        adam_pkg::bus_addr_u a;
        a = `ADAM_SYSCFG_BASE;
        a.cfg.unit = unit[3:0];
        a.cfg.reg_sel = sel[1:0];
        return a;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected 0x%08h got 0x%08h", name, expected, actual);
            value_errors++;
        end
    endtask

    // one request, response taken on the falling edge after acceptance
    task automatic transfer(input logic [31:0] addr, input logic we, input logic [3:0] be,
                            input logic [31:0] wdata, input logic [31:0] exp_rdata,
                            input logic exp_err);
        @(negedge clk);
        req_valid_i = 1'b1;
        req_addr_i = addr;
        req_we_i = we;
        req_be_i = be;
        req_wdata_i = wdata;
        // ready only moves on rising edges, so it is settled here
        while (!req_ready_o) @(negedge clk);
        @(negedge clk);
        req_valid_i = 1'b0;
        if (!rsp_valid_o) begin
            $display("no response one cycle after the request was accepted");
            other_errors++;
        end
        check_value("rsp_rdata_o", exp_rdata, rsp_rdata_o);
        check_value("rsp_err_o", 32'(exp_err), 32'(rsp_err_o));
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] wdata, input logic exp_err);
        transfer(addr, 1'b1, be, wdata, 32'h0, exp_err);
    endtask

    task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp_rdata,
                            input logic exp_err);
        transfer(addr, 1'b0, 4'hf, 32'h0, exp_rdata, exp_err);
    endtask

    task automatic check_units();
        for (int u = 0; u < `ADAM_NO_UNITS; u++) begin
            check_value($sformatf("unit_rst_o[%0d]", u), 32'(ctrl_model[u][0]),
                        32'(unit_rst_o[u]));
            check_value($sformatf("unit_pause_o[%0d]", u), 32'(ctrl_model[u][1]),
                        32'(unit_pause_o[u]));
            check_value($sformatf("unit_boot_addr_o[%0d]", u), boot_model[u],
                        unit_boot_addr_o[u]);
        end
    endtask

    task automatic read_all_cfg();
        for (int u = 0; u < `ADAM_NO_UNITS; u++) begin
            bus_read(cfg_addr(u, 0), 32'(ctrl_model[u]), 1'b0);
            bus_read(cfg_addr(u, 1), boot_model[u], 1'b0);
        end
    endtask

    task automatic read_all_mem();
        for (int i = 0; i < MEM_WORDS; i++) begin
            bus_read(32'(i * 4), mem_model[i], 1'b0);
        end
    endtask

    task automatic test_reset_state();
        // no response pending out of reset
        check_value("rsp_valid_o", 32'h0, 32'(rsp_valid_o));
        check_units();
        read_all_cfg();
    endtask

    task automatic test_lpmem();
        int idx;
        logic [31:0] data;
        logic [3:0] be;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model[i] = $urandom;
            bus_write(32'(i * 4), 4'hf, mem_model[i], 1'b0);
        end
        repeat (200) begin
            idx = int'($urandom % MEM_WORDS);
            data = $urandom;
            be = 4'($urandom);
            bus_write(32'(idx * 4), be, data, 1'b0);
            // strobed lanes replace bytes of the old word
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem_model[idx][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end
        read_all_mem();
    endtask

    task automatic test_syscfg();
        logic [31:0] data;
        for (int u = `ADAM_NO_UNITS - 1; u >= 0; u--) begin
            data = $urandom;
            bus_write(cfg_addr(u, 0), 4'($urandom), data, 1'b0);
            ctrl_model[u] = data[1:0];
            check_units();
            data = $urandom;
            bus_write(cfg_addr(u, 1), 4'($urandom), data, 1'b0);
            boot_model[u] = data;
            check_units();
        end
        read_all_cfg();
    endtask

    task automatic test_errors();
        // outside both windows
        bus_write(32'h0000_0400, 4'hf, 32'hffff_ffff, 1'b1);
        bus_read(32'h0002_0000, 32'h0, 1'b1);
        bus_write(`ADAM_SYSCFG_BASE + 32'h100, 4'hf, 32'h0, 1'b1);
        // misaligned
        bus_write(32'h0000_0005, 4'hf, 32'hffff_ffff, 1'b1);
        bus_write(cfg_addr(0, 1) + 2, 4'hf, 32'h0, 1'b1);
        // syscfg holes and units past the last one
        bus_write(cfg_addr(1, 2), 4'hf, 32'hffff_ffff, 1'b1);
        bus_read(cfg_addr(2, 3), 32'h0, 1'b1);
        bus_write(cfg_addr(4, 0), 4'hf, 32'h0, 1'b1);
        bus_write(cfg_addr(15, 1), 4'hf, 32'hffff_ffff, 1'b1);
        check_units();
        read_all_cfg();
        read_all_mem();
    endtask

    task automatic test_back_pressure();
        logic [31:0] held_rdata;
        logic held_err;
        @(negedge clk);
        rsp_ready_i = 1'b0;
        req_valid_i = 1'b1;
        req_we_i = 1'b0;
        req_addr_i = cfg_addr(2, 1);
        @(negedge clk);
        // first request taken, the second one has to wait
        req_addr_i = 32'h0000_0008;
        held_rdata = rsp_rdata_o;
        held_err = rsp_err_o;
        check_value("rsp_rdata_o", boot_model[2], held_rdata);
        check_value("rsp_err_o", 32'h0, 32'(held_err));
        repeat (4) begin
            if (!rsp_valid_o || req_ready_o) begin
                $display("response lost or request taken while rsp_ready_i was low");
                other_errors++;
            end
            check_value("rsp_rdata_o", held_rdata, rsp_rdata_o);
            check_value("rsp_err_o", 32'(held_err), 32'(rsp_err_o));
            @(negedge clk);
        end
        rsp_ready_i = 1'b1;
        @(negedge clk);
        req_valid_i = 1'b0;
        if (!rsp_valid_o) begin
            $display("second response missing after rsp_ready_i was released");
            other_errors++;
        end
        check_value("rsp_rdata_o", mem_model[2], rsp_rdata_o);
        check_value("rsp_err_o", 32'h0, 32'(rsp_err_o));
    endtask

    initial begin
        int seed;
        seed = $urandom(32'h8da34a04);
        for (int u = 0; u < `ADAM_NO_UNITS; u++) begin
            ctrl_model[u] = 2'b01;
            boot_model[u] = `ADAM_BOOT_ADDR_RST;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        test_reset_state();
        test_lpmem();
        test_syscfg();
        test_errors();
        test_back_pressure();
        $display("%0d value mismatches, %0d protocol errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: adam_lsdom.f
+incdir+logic
logic/adam_pkg.sv
logic/adam_req_if.sv
logic/adam_req_decode.sv
logic/adam_lpmem.sv
logic/adam_syscfg.sv
logic/adam_rsp_reg.sv
logic/adam_lsdom.sv
test/adam_lsdom_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= adam_lsdom_tb
FILELIST  ?= adam_lsdom.f
BUILD_DIR ?= build
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
